/* Makefile */
TOP = lspExpandTb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* flist.f */
rtl/lspPkg.sv
rtl/scratchMemIf.sv
rtl/pairAdjustIf.sv
rtl/scratchMemory.sv
rtl/lspPairAdjust.sv
rtl/lspExpandCtrl.sv
rtl/lspExpandTop.sv
test/lspExpand_properties.sv
test/lspExpandTb.sv

/* rtl/lspExpandCtrl.sv */
`timescale 1ns/1ps

module lspExpandCtrl
(
	input logic clk,
	input logic rst,
	input logic start,
	output logic busy,
	output logic done,
	scratchMemIf.engine mem,
	pairAdjustIf.engine pair
);

	logic [lspPkg::stateWidth-1:0] state;
	logic [lspPkg::stateWidth-1:0] nextState;

	// Index of the current word, the previous one sits just below it
	logic [lspPkg::pairIdxWidth-1:0] pairIdx;
	logic lastPair;
	logic pairFinished;
	logic passEnd;

	logic [lspPkg::addrWidth-1:0] idxOffset;
	logic [lspPkg::addrWidth-1:0] curAddr;
	logic [lspPkg::addrWidth-1:0] prevAddr;
	logic [lspPkg::addrWidth-1:0] gapAddr;

	logic signed [lspPkg::wordWidth-1:0] gapReg;
	logic signed [lspPkg::wordWidth-1:0] prevReg;
	logic signed [lspPkg::wordWidth-1:0] curReg;

	//////////////////////////////////////////////////////////////////////
	// Buffer addressing
	//////////////////////////////////////////////////////////////////////

	assign idxOffset = {{(lspPkg::addrWidth - lspPkg::pairIdxWidth){1'b0}}, pairIdx};
	assign curAddr = lspPkg::bufBase + idxOffset;
	assign prevAddr = curAddr - 1'b1;
	assign gapAddr = lspPkg::bufBase + lspPkg::gapOffset;

	assign lastPair = int'(pairIdx) == lspPkg::pairCount - 1;

	// A pair ends after evaluation, or after its second write
	assign pairFinished = (state == lspPkg::stEval && !pair.adjust) ||
		(state == lspPkg::stWrCur);
	assign passEnd = pairFinished && lastPair;

	//////////////////////////////////////////////////////////////////////
	// Sequencing
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		case (state)
			lspPkg::stIdle:
				if (start && !busy)
					nextState = lspPkg::stGapRd;
			lspPkg::stGapRd:
				nextState = lspPkg::stGapLatch;
			lspPkg::stGapLatch:
				nextState = lspPkg::stRdPrev;
			lspPkg::stRdPrev:
				nextState = lspPkg::stRdCur;
			lspPkg::stRdCur:
				nextState = lspPkg::stDataWait;
			lspPkg::stDataWait:
				nextState = lspPkg::stEval;
			lspPkg::stEval:
				if (pair.adjust)
					nextState = lspPkg::stWrPrev;
			lspPkg::stWrPrev:
				nextState = lspPkg::stWrCur;
			default:
				nextState = state;
		endcase

		// Either move to the next pair or close the pass
		if (pairFinished)
			nextState = lastPair ? lspPkg::stIdle : lspPkg::stRdPrev;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= lspPkg::stIdle;
			busy <= 1'b0;
			done <= 1'b0;
			pairIdx <= 1'b1;
		end
		else
		begin
			state <= nextState;
			done <= passEnd;
			if (state == lspPkg::stIdle && start && !busy)
			begin
				busy <= 1'b1;
				pairIdx <= 1'b1;
			end
			else if (passEnd)
			begin
				busy <= 1'b0;
			end
			else if (pairFinished)
			begin
				pairIdx <= pairIdx + 1'b1;
			end
		end
	end

	// Read data lands one cycle after its address was issued
	always_ff @(posedge clk)
	begin
		if (state == lspPkg::stGapLatch)
			gapReg <= mem.readData;
		if (state == lspPkg::stRdCur)
			prevReg <= mem.readData;
		if (state == lspPkg::stDataWait)
			curReg <= mem.readData;
	end

	//////////////////////////////////////////////////////////////////////
	// Memory and arithmetic drive
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (state)
			lspPkg::stGapRd:
				mem.readAddr = gapAddr;
			lspPkg::stRdCur:
				mem.readAddr = curAddr;
			default:
				mem.readAddr = prevAddr;
		endcase
	end

	// Registers hold still through the writes, so results stay valid
	assign mem.writeEn = (state == lspPkg::stWrPrev) || (state == lspPkg::stWrCur);
	assign mem.writeAddr = (state == lspPkg::stWrPrev) ? prevAddr : curAddr;
	assign mem.writeData = (state == lspPkg::stWrPrev) ? pair.newPrev : pair.newCur;
	assign mem.busy = busy;

	assign pair.prev = prevReg;
	assign pair.cur = curReg;
	assign pair.gap = gapReg;

endmodule

/* rtl/lspExpandTop.sv */
`timescale 1ns/1ps

module lspExpandTop
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic hostWriteEn,
	input logic [lspPkg::addrWidth-1:0] hostWriteAddr,
	input logic [lspPkg::wordWidth-1:0] hostWriteData,
	input logic [lspPkg::addrWidth-1:0] hostReadAddr,
	output logic [lspPkg::wordWidth-1:0] hostReadData,
	output logic busy,
	output logic done
);

	scratchMemIf memBus ();
	pairAdjustIf pairBus ();

	//////////////////////////////////////////////////////////////////////
	// Expansion engine
	//////////////////////////////////////////////////////////////////////

	lspExpandCtrl ctrl
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.done(done),
		.mem(memBus.engine),
		.pair(pairBus.engine)
	);

	// Saturating pair arithmetic
	lspPairAdjust arith
	(
		.pair(pairBus.arith)
	);

	//////////////////////////////////////////////////////////////////////
	// Scratch buffer, host side exposed at the top
	//////////////////////////////////////////////////////////////////////

	scratchMemory scratch
	(
		.clk(clk),
		.mem(memBus.memory),
		.hostWriteEn(hostWriteEn),
		.hostWriteAddr(hostWriteAddr),
		.hostWriteData(hostWriteData),
		.hostReadAddr(hostReadAddr),
		.hostReadData(hostReadData)
	);

endmodule

/* rtl/lspPairAdjust.sv */
`timescale 1ns/1ps

module lspPairAdjust
(
	pairAdjustIf.arith pair
);

	// One guard bit above the word keeps the raw result before clipping
	logic signed [lspPkg::wordWidth:0] diffWide;
	logic signed [lspPkg::wordWidth:0] sumWide;
	logic signed [lspPkg::wordWidth:0] prevWide;
	logic signed [lspPkg::wordWidth:0] curWide;

	logic signed [lspPkg::wordWidth-1:0] diff;
	logic signed [lspPkg::wordWidth-1:0] sum;
	logic signed [lspPkg::wordWidth-1:0] half;

	// Clip a guarded result back into 16 bits
	function automatic logic signed [lspPkg::wordWidth-1:0] saturate
	(
		input logic signed [lspPkg::wordWidth:0] x
	);
		logic signed [lspPkg::wordWidth:0] hiLimit;
		logic signed [lspPkg::wordWidth:0] loLimit;
		hiLimit = lspPkg::wordMax;
		loLimit = lspPkg::wordMin;
		if (x > hiLimit)
			return lspPkg::wordMax;
		else if (x < loLimit)
			return lspPkg::wordMin;
		else
			return x[lspPkg::wordWidth-1:0];
	endfunction

	always_comb
	begin
		// half = (sat(prev - cur) + gap) >> 1, each step saturated
		diffWide = pair.prev - pair.cur;
		diff = saturate(diffWide);
		sumWide = diff + pair.gap;
		sum = saturate(sumWide);
		half = sum >>> 1;

		// Push the pair apart by half on each side
		prevWide = pair.prev - half;
		curWide = pair.cur + half;
		pair.newPrev = saturate(prevWide);
		pair.newCur = saturate(curWide);

		// Only a positive half means the pair is too close
		pair.adjust = half > 0;
	end

endmodule

/* rtl/lspPkg.sv */
package lspPkg;

	//////////////////////////////////////////////////////////////////////
	// Word and memory geometry
	//////////////////////////////////////////////////////////////////////

	localparam int wordWidth = 16;
	localparam int addrWidth = 11;
	localparam int memDepth = 2048;

	// Coefficient buffer, word i sits at bufBase + i
	localparam logic [addrWidth-1:0] bufBase = 11'h2A0;

	// Gap word follows the ten coefficients
	localparam logic [addrWidth-1:0] gapOffset = 11'd10;

	// First pass spaces words 0..4, pairs 1..4
	localparam int pairCount = 5;
	localparam int pairIdxWidth = $clog2(pairCount);

	// 16-bit saturation limits
	localparam logic signed [wordWidth-1:0] wordMax = 16'sh7FFF;
	localparam logic signed [wordWidth-1:0] wordMin = 16'sh8000;

	//////////////////////////////////////////////////////////////////////
	// Expansion FSM state codes
	//////////////////////////////////////////////////////////////////////

	localparam int stateWidth = 4;

	localparam logic [stateWidth-1:0] stIdle = 4'd0;
	localparam logic [stateWidth-1:0] stGapRd = 4'd1;
	localparam logic [stateWidth-1:0] stGapLatch = 4'd2;
	localparam logic [stateWidth-1:0] stRdPrev = 4'd3;
	localparam logic [stateWidth-1:0] stRdCur = 4'd4;
	localparam logic [stateWidth-1:0] stDataWait = 4'd5;
	localparam logic [stateWidth-1:0] stEval = 4'd6;
	localparam logic [stateWidth-1:0] stWrPrev = 4'd7;
	localparam logic [stateWidth-1:0] stWrCur = 4'd8;

endpackage

/* rtl/pairAdjustIf.sv */
`timescale 1ns/1ps

// One spacing decision between two neighbouring coefficients
interface pairAdjustIf;

	logic signed [lspPkg::wordWidth-1:0] prev;
	logic signed [lspPkg::wordWidth-1:0] cur;
	logic signed [lspPkg::wordWidth-1:0] gap;

	// Combinational results
	logic signed [lspPkg::wordWidth-1:0] newPrev;
	logic signed [lspPkg::wordWidth-1:0] newCur;
	logic adjust;

	modport engine
	(
		output prev, cur, gap,
		input newPrev, newCur, adjust
	);

	modport arith
	(
		input prev, cur, gap,
		output newPrev, newCur, adjust
	);

endinterface

/* rtl/scratchMemIf.sv */
`timescale 1ns/1ps

// Engine side of the scratch memory
interface scratchMemIf;

	logic [lspPkg::addrWidth-1:0] readAddr;
	// Valid one cycle after readAddr
	logic [lspPkg::wordWidth-1:0] readData;
	logic [lspPkg::addrWidth-1:0] writeAddr;
	logic [lspPkg::wordWidth-1:0] writeData;
	logic writeEn;
	// Hands both memory ports to the engine
	logic busy;

	modport engine
	(
		output readAddr, writeAddr, writeData, writeEn, busy,
		input readData
	);

	modport memory
	(
		input readAddr, writeAddr, writeData, writeEn, busy,
		output readData
	);

endinterface

/* rtl/scratchMemory.sv */
`timescale 1ns/1ps

module scratchMemory
(
	input logic clk,
	scratchMemIf.memory mem,
	input logic hostWriteEn,
	input logic [lspPkg::addrWidth-1:0] hostWriteAddr,
	input logic [lspPkg::wordWidth-1:0] hostWriteData,
	input logic [lspPkg::addrWidth-1:0] hostReadAddr,
	output logic [lspPkg::wordWidth-1:0] hostReadData
);

	logic [lspPkg::wordWidth-1:0] words [lspPkg::memDepth];
	logic [lspPkg::wordWidth-1:0] readReg;

	logic wrEn;
	logic [lspPkg::addrWidth-1:0] wrAddr;
	logic [lspPkg::wordWidth-1:0] wrData;
	logic [lspPkg::addrWidth-1:0] rdAddr;

	// Port owner follows busy, host is locked out during a pass
	always_comb
	begin
		if (mem.busy)
		begin
			wrEn = mem.writeEn;
			wrAddr = mem.writeAddr;
			wrData = mem.writeData;
			rdAddr = mem.readAddr;
		end
		else
		begin
			wrEn = hostWriteEn;
			wrAddr = hostWriteAddr;
			wrData = hostWriteData;
			rdAddr = hostReadAddr;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrEn)
		begin
			words[wrAddr] <= wrData;
		end
		readReg <= words[rdAddr];
	end

	// One read register shared by both sides
	assign mem.readData = readReg;
	assign hostReadData = readReg;

endmodule

/* test/lspExpandTb.sv */
`timescale 1ns/1ps

module lspExpandTb;

	localparam int clkPeriod = 40;
	localparam int bufWords = 11;
	localparam int randomFrames = 200;
	// Worst case pass is gap fetch plus four pairs that all write back
	localparam int passCycles = 3 + (lspPkg::pairCount - 1) * 6 + 2;
	localparam int ioCycles = (bufWords + 1) + 2 * bufWords + 2;
	localparam int timeoutCycles = 2 * (randomFrames + 10) * (passCycles + ioCycles) + 20;

	logic clk;
	logic rst;
	logic start;
	logic hostWriteEn;
	logic [lspPkg::addrWidth-1:0] hostWriteAddr;
	logic [lspPkg::wordWidth-1:0] hostWriteData;
	logic [lspPkg::addrWidth-1:0] hostReadAddr;
	logic [lspPkg::wordWidth-1:0] hostReadData;
	logic busy;
	logic done;

	int frame [bufWords];
	int expWords [bufWords];
	logic [15:0] lfsrState = 16'd26;
	string testName;
	int reqCount = 0;
	int ackCount = 0;
	int doneCount = 0;
	int errorCount = 0;
	int errorsBefore = 0;
	int testsRun = 0;
	int testsFailed = 0;

	lspExpandTop uut
	(
		.clk(clk), .rst(rst), .start(start),
		.hostWriteEn(hostWriteEn), .hostWriteAddr(hostWriteAddr), .hostWriteData(hostWriteData),
		.hostReadAddr(hostReadAddr), .hostReadData(hostReadData),
		.busy(busy), .done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial
	begin
		#(timeoutCycles * clkPeriod);
		$display("Timeout: the run did not end within %0d cycles", timeoutCycles);
		$display("RESULT: FAIL");
		$finish;
	end

	always @(negedge clk)
	begin
		if (done)
			doneCount++;
	end

	//////////////////////////////////////////////////////////////////////
	// Random words and the reference model
	//////////////////////////////////////////////////////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic int randomBits(int n);
		int value;
		logic fb;
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
			lfsrState = {lfsrState[14:0], fb};
			value = (value << 1) | int'(fb);
		end
		return value;
	endfunction

	function automatic int toSigned(int raw);
		return int'($signed(raw[15:0]));
	endfunction

	function automatic int sat16(int x);
		if (x > 32767)
			return 32767;
		if (x < -32768)
			return -32768;
		return x;
	endfunction

	// Pairs one to four in order, so an adjusted word feeds the next pair
	function automatic void spaceModel();
		int half;
		for (int i = 1; i < lspPkg::pairCount; i++)
		begin
			half = sat16(sat16(expWords[i-1] - expWords[i]) + expWords[int'(lspPkg::gapOffset)]);
			half = half >>> 1;
			if (half > 0)
			begin
				expWords[i-1] = sat16(expWords[i-1] - half);
				expWords[i] = sat16(expWords[i] + half);
			end
		end
	endfunction

	task automatic checkValue(string what, int expected, int actual);
		if (expected !== actual)
		begin
			$display("Mismatch %s %s: expected %0d, actual %0d", testName, what, expected, actual);
			errorCount++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Host side sequences
	//////////////////////////////////////////////////////////////////////

	task automatic loadFrame();
		for (int i = 0; i < bufWords; i++)
		begin
			@(posedge clk);
			hostWriteEn <= 1'b1;
			hostWriteAddr <= lspPkg::bufBase + 11'(i);
			hostWriteData <= 16'(frame[i]);
			expWords[i] = frame[i];
		end
		@(posedge clk);
		hostWriteEn <= 1'b0;
	endtask

	task automatic pulseStart();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic waitDone();
		do
			@(negedge clk);
		while (!done);
	endtask

	// Hands the readback to the compare process and waits for it
	task automatic compareBuffer();
		reqCount++;
		wait (ackCount == reqCount);
	endtask

	task automatic runFrame();
		loadFrame();
		pulseStart();
		waitDone();
		spaceModel();
		compareBuffer();
	endtask

	task automatic finishTest();
		testsRun++;
		if (errorCount == errorsBefore)
			$display("Test %s: passed", testName);
		else
		begin
			testsFailed++;
			$display("Test %s: failed, %0d mismatches", testName, errorCount - errorsBefore);
		end
		errorsBefore = errorCount;
	endtask

	// Reads back each word through the registered host port
	initial
	begin
		hostReadAddr = '0;
		forever
		begin
			wait (reqCount != ackCount);
			for (int i = 0; i < bufWords; i++)
			begin
				@(posedge clk);
				hostReadAddr <= lspPkg::bufBase + 11'(i);
				@(posedge clk);
				@(negedge clk);
				checkValue($sformatf("word %0d", i), expWords[i], toSigned(hostReadData));
			end
			ackCount++;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int donesBefore;
		rst = 1'b1;
		start = 1'b0;
		hostWriteEn = 1'b0;
		hostWriteAddr = '0;
		hostWriteData = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		testName = "reset_idle";
		frame = '{-7, 300, 1234, -4000, 32767, -32768, 5, 6, 77, 888, 99};
		loadFrame();
		@(negedge clk);
		checkValue("busy", 0, int'(busy));
		checkValue("done pulses", 0, doneCount);
		compareBuffer();
		finishTest();

		testName = "spaced";
		frame = '{1000, 2000, 3000, 4000, 5000, 6000, 7000, 8000, 9000, 10000, 100};
		runFrame();
		finishTest();

		testName = "close_pairs";
		frame = '{2000, 2010, 1900, 3000, 2990, 60, 70, 80, 90, 95, 200};
		runFrame();
		frame = '{500, 520, 540, 560, 580, 600, 620, 640, 660, 680, 300};
		runFrame();
		finishTest();

		testName = "extremes";
		frame = '{32767, -32768, 32700, -32700, 0, 1, 2, 3, 4, 5, 32767};
		runFrame();
		frame = '{-32768, -32768, 32767, 32767, -32768, 9, 8, 7, 6, 5, -32768};
		runFrame();
		// Adjusted words clip at both limits
		frame = '{-32768, -32768, 32767, 32767, 0, 10, 20, 30, 40, 50, 32767};
		runFrame();
		finishTest();

		testName = "random";
		for (int f = 0; f < randomFrames; f++)
		begin
			for (int i = 0; i < bufWords - 1; i++)
				frame[i] = toSigned(randomBits(16));
			frame[bufWords-1] = randomBits(12);
			runFrame();
		end
		finishTest();

		testName = "busy_lockout";
		frame = '{800, 790, 810, 805, 820, 11, 12, 13, 14, 15, 400};
		loadFrame();
		donesBefore = doneCount;
		pulseStart();
		repeat (2) @(posedge clk);
		@(negedge clk);
		checkValue("busy", 1, int'(busy));
		// A second start and a host write land in the middle of the pass
		@(posedge clk);
		start <= 1'b1;
		hostWriteEn <= 1'b1;
		hostWriteAddr <= lspPkg::bufBase + 11'd2;
		hostWriteData <= 16'h1234;
		@(posedge clk);
		start <= 1'b0;
		hostWriteEn <= 1'b0;
		waitDone();
		repeat (passCycles) @(negedge clk);
		checkValue("done pulses", 1, doneCount - donesBefore);
		spaceModel();
		compareBuffer();
		finishTest();

		$display("%0d tests run, %0d failed, %0d mismatches", testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* test/lspExpand_properties.sv */
`timescale 1ns/1ps

module expandControlChecks
(
	input logic clk,
	input logic rst,
	input logic busy,
	input logic done,
	input logic writeEn
);

	// done is a one-cycle pulse that closes the pass
	assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done stayed high for a second cycle");

	assert property (@(posedge clk) disable iff (rst) done |-> $fell(busy))
		else $error("done did not coincide with busy falling");

	// Engine writes only inside a pass
	assert property (@(posedge clk) disable iff (rst) !busy |-> !writeEn)
		else $error("scratch write while the engine was idle");

	// Synchronous reset clears every control output
	assert property (@(posedge clk) rst |=> !busy && !done && !writeEn)
		else $error("control output active during reset");

endmodule

bind lspExpandTop expandControlChecks controlChecks
(
	.clk(clk),
	.rst(rst),
	.busy(busy),
	.done(done),
	.writeEn(memBus.writeEn)
);
